// ==== stream_pkg.sv ====
`default_nettype none

// Definitions that describe where a telemetry word came from

package stream_pkg;

    // Source queue of a word. The encoding doubles as the queue index
    // inside the FIFO, so low priority is queue 0 and high priority is queue 1
    typedef enum logic {
        PRIO_LOW  = 1'b0,
        PRIO_HIGH = 1'b1
    } priority_t;

endpackage

`default_nettype wire

// ==== framer_pkg.sv ====
`default_nettype none

// Definitions that describe the framing applied at the output

package framer_pkg;

    typedef enum logic {
        FR_DATA    = 1'b0,
        FR_TRAILER = 1'b1
    } framer_state_t;

    // Top nibble of a trailer word, one code per source priority
    typedef enum logic [3:0] {
        TAG_LOW  = 4'hA,
        TAG_HIGH = 4'h5
    } trailer_tag_t;

endpackage

`default_nettype wire

// ==== dual_read_register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module dual_read_register_file #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 4
) (
    input  wire                  clock,
    input  wire                  reset,
    input  wire [DATA_WIDTH-1:0] data_a,
    input  wire [ADDR_WIDTH-1:0] addr_a,
    input  wire                  we_a,
    input  wire [ADDR_WIDTH-1:0] addr_b,
    output logic [DATA_WIDTH-1:0] q_b
);

    localparam int WORDS = 2 ** ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] memory [WORDS];

    // Cleared on reset so that a read of a location never written is defined
    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < WORDS; i++) begin
                memory[i] <= '0;
            end
        end else if (we_a) begin
            memory[addr_a] <= data_a;
        end
    end

    // Read port is asynchronous, the FIFO samples it on the pop edge
    assign q_b = memory[addr_b];

endmodule

`default_nettype wire

// ==== prioritised_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module prioritised_fifo
    import stream_pkg::*;
#(
    parameter int DATA_WIDTH = 32,
    parameter int FIFO_DEPTH = 16
) (
    input  wire                   clock,
    input  wire                   reset,

    input  wire [DATA_WIDTH-1:0]  hp_data,
    input  wire                   hp_last,
    input  wire                   hp_valid,
    output logic                  hp_ready,

    input  wire [DATA_WIDTH-1:0]  lp_data,
    input  wire                   lp_last,
    input  wire                   lp_valid,
    output logic                  lp_ready,

    input  wire                   fifo_ready,
    output logic [DATA_WIDTH-1:0] fifo_data,
    output logic                  fifo_last,
    output priority_t             fifo_priority,
    output logic                  fifo_valid
);

    localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int FILL_WIDTH = ADDR_WIDTH + 1;

    // Per-queue signals, indexed by priority_t value
    logic [DATA_WIDTH-1:0] in_data [2];
    logic [DATA_WIDTH-1:0] rd_data [2];
    logic [1:0]            in_last;
    logic [1:0]            in_valid;
    logic [1:0]            in_ready;
    logic [1:0]            rd_last;
    logic [1:0]            push;
    logic [1:0]            pop;
    logic [1:0]            has_word;

    logic                  locked;
    priority_t             locked_priority;
    priority_t             pop_priority;
    logic                  issue_allowed;

    assign in_data[PRIO_LOW]   = lp_data;
    assign in_data[PRIO_HIGH]  = hp_data;
    assign in_last[PRIO_LOW]   = lp_last;
    assign in_last[PRIO_HIGH]  = hp_last;
    assign in_valid[PRIO_LOW]  = lp_valid;
    assign in_valid[PRIO_HIGH] = hp_valid;
    assign lp_ready            = in_ready[PRIO_LOW];
    assign hp_ready            = in_ready[PRIO_HIGH];

    for (genvar q = 0; q < 2; q++) begin : gen_queue
        logic [DATA_WIDTH-1:0] wr_data;
        logic                  wr_last;
        logic                  wr_en;
        logic [ADDR_WIDTH-1:0] wr_addr;
        logic [ADDR_WIDTH-1:0] rd_addr;
        logic [FILL_WIDTH-1:0] fill_level;
        logic [DATA_WIDTH:0]   mem_q;

        // A word is taken only when the source offers it and there is room
        assign push[q]     = in_valid[q] && in_ready[q];
        assign in_ready[q] = fill_level < FILL_WIDTH'(FIFO_DEPTH);

        // The fill level already counts a word sitting in the write stage,
        // which cannot be read until its write has committed
        assign has_word[q] = fill_level > FILL_WIDTH'(wr_en);

        // Write stage strobe and pointer, the pointer moves as the write commits
        always_ff @(posedge clock) begin
            if (!reset) begin
                wr_en   <= 1'b0;
                wr_addr <= '0;
            end else begin
                wr_en <= push[q];
                if (wr_en) begin
                    wr_addr <= wr_addr + 1'b1;
                end
            end
        end

        always_ff @(posedge clock) begin
            if (push[q]) begin
                wr_data <= in_data[q];
                wr_last <= in_last[q];
            end
        end

        always_ff @(posedge clock) begin
            if (!reset) begin
                rd_addr    <= '0;
                fill_level <= '0;
            end else begin
                if (pop[q]) begin
                    rd_addr <= rd_addr + 1'b1;
                end
                case ({push[q], pop[q]})
                    2'b10:   fill_level <= fill_level + 1'b1;
                    2'b01:   fill_level <= fill_level - 1'b1;
                    default: fill_level <= fill_level;
                endcase
            end
        end

        // The last flag is stored in the top bit beside the payload
        dual_read_register_file #(
            .DATA_WIDTH (DATA_WIDTH + 1),
            .ADDR_WIDTH (ADDR_WIDTH)
        ) u_memory (
            .clock  (clock),
            .reset  (reset),
            .data_a ({wr_last, wr_data}),
            .addr_a (wr_addr),
            .we_a   (wr_en),
            .addr_b (rd_addr),
            .q_b    (mem_q)
        );

        assign rd_data[q] = mem_q[DATA_WIDTH-1:0];
        assign rd_last[q] = mem_q[DATA_WIDTH];
    end

    // One idle cycle follows every last word so the framer can insert its trailer
    assign issue_allowed = fifo_ready && !(fifo_valid && fifo_last);

    always_comb begin
        pop = 2'b00;
        if (issue_allowed) begin
            if (locked) begin
                // Stay on the packet in progress, even if the other queue has words
                pop[locked_priority] = has_word[locked_priority];
            end else if (has_word[PRIO_HIGH]) begin
                pop[PRIO_HIGH] = 1'b1;
            end else begin
                pop[PRIO_LOW] = has_word[PRIO_LOW];
            end
        end
    end

    assign pop_priority = pop[PRIO_HIGH] ? PRIO_HIGH : PRIO_LOW;

    always_ff @(posedge clock) begin
        if (!reset) begin
            fifo_valid      <= 1'b0;
            fifo_last       <= 1'b0;
            locked          <= 1'b0;
            locked_priority <= PRIO_LOW;
        end else begin
            fifo_valid <= |pop;
            fifo_last  <= (|pop) && rd_last[pop_priority];
            if (|pop) begin
                // Lock until the packet's last word leaves the queue
                locked          <= !rd_last[pop_priority];
                locked_priority <= pop_priority;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (|pop) begin
            fifo_data     <= rd_data[pop_priority];
            fifo_priority <= pop_priority;
        end
    end

endmodule

`default_nettype wire

// ==== packet_framer.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_framer
    import stream_pkg::*;
    import framer_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  wire                   clock,
    input  wire                   reset,

    input  wire [DATA_WIDTH-1:0]  fifo_data,
    input  wire                   fifo_last,
    input  wire priority_t        fifo_priority,
    input  wire                   fifo_valid,
    output logic                  fifo_ready,

    input  wire                   out_ready,
    output logic [DATA_WIDTH-1:0] out_data,
    output logic                  out_last,
    output logic                  out_valid
);

    localparam int COUNT_WIDTH = DATA_WIDTH - 4;

    framer_state_t          state;
    logic [COUNT_WIDTH-1:0] word_count;
    priority_t              packet_priority;
    trailer_tag_t           trailer_tag;

    // The framer adds no buffering of its own, so the consumer's level
    // is the FIFO's permission to issue
    assign fifo_ready = out_ready;

    assign trailer_tag = (packet_priority == PRIO_HIGH) ? TAG_HIGH : TAG_LOW;

    // Control path
    always_ff @(posedge clock) begin
        if (!reset) begin
            state      <= FR_DATA;
            word_count <= '0;
            out_valid  <= 1'b0;
            out_last   <= 1'b0;
        end else begin
            case (state)
                FR_DATA: begin
                    out_last  <= 1'b0;
                    out_valid <= fifo_valid;
                    if (fifo_valid) begin
                        word_count <= word_count + 1'b1;
                        if (fifo_last) begin
                            state <= FR_TRAILER;
                        end
                    end
                end
                FR_TRAILER: begin
                    // The FIFO is idle in this cycle, so nothing is dropped
                    out_valid  <= 1'b1;
                    out_last   <= 1'b1;
                    word_count <= '0;
                    state      <= FR_DATA;
                end
                default: begin
                    state <= FR_DATA;
                end
            endcase
        end
    end

    // Data path
    always_ff @(posedge clock) begin
        case (state)
            FR_DATA: begin
                if (fifo_valid) begin
                    out_data        <= fifo_data;
                    packet_priority <= fifo_priority;
                end
            end
            FR_TRAILER: begin
                // Tag in the top nibble, data word count below it
                out_data <= {trailer_tag, word_count};
            end
            default: begin
                out_data <= out_data;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== telemetry_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module telemetry_mux
    import stream_pkg::*;
#(
    parameter int DATA_WIDTH = 32,
    parameter int FIFO_DEPTH = 16
) (
    input  wire                   clock,
    input  wire                   reset,

    // Fault and event packets
    input  wire [DATA_WIDTH-1:0]  hp_data,
    input  wire                   hp_last,
    input  wire                   hp_valid,
    output logic                  hp_ready,

    // Sampled data packets
    input  wire [DATA_WIDTH-1:0]  lp_data,
    input  wire                   lp_last,
    input  wire                   lp_valid,
    output logic                  lp_ready,

    input  wire                   out_ready,
    output logic [DATA_WIDTH-1:0] out_data,
    output logic                  out_last,
    output logic                  out_valid
);

    logic [DATA_WIDTH-1:0] fifo_data;
    logic                  fifo_last;
    priority_t             fifo_priority;
    logic                  fifo_valid;
    logic                  fifo_ready;

    prioritised_fifo #(
        .DATA_WIDTH (DATA_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clock         (clock),
        .reset         (reset),
        .hp_data       (hp_data),
        .hp_last       (hp_last),
        .hp_valid      (hp_valid),
        .hp_ready      (hp_ready),
        .lp_data       (lp_data),
        .lp_last       (lp_last),
        .lp_valid      (lp_valid),
        .lp_ready      (lp_ready),
        .fifo_ready    (fifo_ready),
        .fifo_data     (fifo_data),
        .fifo_last     (fifo_last),
        .fifo_priority (fifo_priority),
        .fifo_valid    (fifo_valid)
    );

    // Appends the priority tag and word count after each packet
    packet_framer #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_framer (
        .clock         (clock),
        .reset         (reset),
        .fifo_data     (fifo_data),
        .fifo_last     (fifo_last),
        .fifo_priority (fifo_priority),
        .fifo_valid    (fifo_valid),
        .fifo_ready    (fifo_ready),
        .out_ready     (out_ready),
        .out_data      (out_data),
        .out_last      (out_last),
        .out_valid     (out_valid)
    );

endmodule

`default_nettype wire

// ==== telemetry_mux_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module telemetry_mux_assert
    import stream_pkg::*;
    import framer_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input wire                  clock,
    input wire                  reset,
    input wire [DATA_WIDTH-1:0] out_data,
    input wire                  out_last,
    input wire                  out_valid,
    input wire                  hp_ready,
    input wire                  lp_ready,
    input wire                  fifo_valid,
    input wire priority_t       fifo_priority
);

    last_has_valid: assert property (@(posedge clock) disable iff (!reset)
        out_last |-> out_valid)
        else $error("out_last is high without out_valid");

    trailer_tag_known: assert property (@(posedge clock) disable iff (!reset)
        out_last |-> (out_data[DATA_WIDTH-1 -: 4] == TAG_LOW ||
                      out_data[DATA_WIDTH-1 -: 4] == TAG_HIGH))
        else $error("Trailer word carries an unknown tag %h", out_data[DATA_WIDTH-1 -: 4]);

    quiet_in_reset: assert property (@(posedge clock)
        !reset |=> !out_valid)
        else $error("out_valid is high during reset");

    // A full queue regains room only through a pop of its own priority,
    // so ready must stay low unless the FIFO issued from that queue
    hp_full_holds: assert property (@(posedge clock) disable iff (!reset)
        !hp_ready |=> (!hp_ready || (fifo_valid && fifo_priority == PRIO_HIGH)))
        else $error("High queue left the full state without a pop");

    lp_full_holds: assert property (@(posedge clock) disable iff (!reset)
        !lp_ready |=> (!lp_ready || (fifo_valid && fifo_priority == PRIO_LOW)))
        else $error("Low queue left the full state without a pop");

endmodule

bind telemetry_mux telemetry_mux_assert #(
    .DATA_WIDTH (DATA_WIDTH)
) u_protocol_assert (
    .clock         (clock),
    .reset         (reset),
    .out_data      (out_data),
    .out_last      (out_last),
    .out_valid     (out_valid),
    .hp_ready      (hp_ready),
    .lp_ready      (lp_ready),
    .fifo_valid    (fifo_valid),
    .fifo_priority (fifo_priority)
);

`default_nettype wire

// ==== tb_telemetry_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_telemetry_mux
    import stream_pkg::*;
    import framer_pkg::*;
();

    localparam int DATA_WIDTH  = 32;
    localparam int FIFO_DEPTH  = 16;
    localparam int COUNT_WIDTH = DATA_WIDTH - 4;

    // The five tests move under 60 words in total and each finishes in well
    // under 200 cycles, so 2000 cycles leaves a wide margin over reset and drains
    localparam int TIMEOUT_CYCLES = 2000;

    logic                  clock;
    logic                  reset;
    logic [DATA_WIDTH-1:0] hp_data;
    logic                  hp_last;
    logic                  hp_valid;
    logic                  hp_ready;
    logic [DATA_WIDTH-1:0] lp_data;
    logic                  lp_last;
    logic                  lp_valid;
    logic                  lp_ready;
    logic                  out_ready;
    logic [DATA_WIDTH-1:0] out_data;
    logic                  out_last;
    logic                  out_valid;

    // Words are kept as {last, data}
    logic [DATA_WIDTH:0] expected_words [$];
    logic [DATA_WIDTH:0] hp_words [$];
    logic [DATA_WIDTH:0] lp_words [$];

    logic [31:0] lfsr_state;
    string       test_name;
    int          words_seen;
    int          cycle_count;

    telemetry_mux #(
        .DATA_WIDTH (DATA_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) telemetry_mux_i (
        .clock     (clock),
        .reset     (reset),
        .hp_data   (hp_data),
        .hp_last   (hp_last),
        .hp_valid  (hp_valid),
        .hp_ready  (hp_ready),
        .lp_data   (lp_data),
        .lp_last   (lp_last),
        .lp_valid  (lp_valid),
        .lp_ready  (lp_ready),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_valid (out_valid)
    );

    always #2 clock = ~clock;

    task automatic stop_on_failure();
        $display("Regression failed");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    task automatic check_value(input string what, input logic [DATA_WIDTH:0] expected,
                               input logic [DATA_WIDTH:0] actual);
        assert (actual === expected) else begin
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, expected, actual);
            stop_on_failure();
        end
    endtask

    // Right-shifting Galois LFSR, taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic random_word(output logic [DATA_WIDTH-1:0] word);
        word = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            word       = {word[DATA_WIDTH-2:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // Queues the stimulus of one packet and appends its words and trailer
    // to the scoreboard, so packets must be built in their output order
    task automatic build_packet(input priority_t prio, input int length);
        logic [DATA_WIDTH-1:0] payload;
        trailer_tag_t          tag;
        for (int i = 0; i < length; i++) begin
            random_word(payload);
            if (prio == PRIO_HIGH) begin
                hp_words.push_back({i == length - 1, payload});
            end else begin
                lp_words.push_back({i == length - 1, payload});
            end
            expected_words.push_back({1'b0, payload});
        end
        tag = (prio == PRIO_HIGH) ? TAG_HIGH : TAG_LOW;
        expected_words.push_back({1'b1, tag, COUNT_WIDTH'(length)});
    endtask

    function automatic logic stream_ready(input priority_t prio);
        return (prio == PRIO_HIGH) ? hp_ready : lp_ready;
    endfunction

    task automatic drive_word(input priority_t prio, input logic valid,
                              input logic [DATA_WIDTH:0] word);
        if (prio == PRIO_HIGH) begin
            hp_valid <= valid;
            hp_data  <= word[DATA_WIDTH-1:0];
            hp_last  <= word[DATA_WIDTH];
        end else begin
            lp_valid <= valid;
            lp_data  <= word[DATA_WIDTH-1:0];
            lp_last  <= word[DATA_WIDTH];
        end
    endtask

    // Ready only moves on a rising edge, so its level at the falling edge
    // decides whether the next rising edge takes the word
    task automatic send_packet(input priority_t prio);
        logic [DATA_WIDTH:0] word;
        int                  count;
        count = (prio == PRIO_HIGH) ? hp_words.size() : lp_words.size();
        @(posedge clock);
        for (int i = 0; i < count; i++) begin
            word = (prio == PRIO_HIGH) ? hp_words.pop_front() : lp_words.pop_front();
            drive_word(prio, 1'b1, word);
            do @(negedge clock); while (!stream_ready(prio));
            @(posedge clock);
        end
        drive_word(prio, 1'b0, '0);
    endtask

    task automatic wait_drained();
        while (expected_words.size() != 0) begin
            @(posedge clock);
        end
        // A few idle cycles catch any word beyond the expected ones
        repeat (4) @(posedge clock);
    endtask

    task automatic test_low_packet();
        test_name = "low_packet";
        build_packet(PRIO_LOW, 5);
        send_packet(PRIO_LOW);
        wait_drained();
    endtask

    task automatic test_high_packet();
        test_name = "high_packet";
        build_packet(PRIO_HIGH, 3);
        send_packet(PRIO_HIGH);
        wait_drained();
    endtask

    task automatic test_priority();
        test_name = "priority";
        @(posedge clock);
        out_ready <= 1'b0;
        build_packet(PRIO_HIGH, 4);
        build_packet(PRIO_LOW, 4);
        send_packet(PRIO_LOW);
        send_packet(PRIO_HIGH);
        repeat (2) @(posedge clock);
        out_ready <= 1'b1;
        wait_drained();
    endtask

    task automatic test_packet_locking();
        int seen_before;
        test_name   = "packet_locking";
        seen_before = words_seen;
        build_packet(PRIO_LOW, 8);
        build_packet(PRIO_HIGH, 2);
        fork
            send_packet(PRIO_LOW);
            begin
                while (words_seen == seen_before) begin
                    @(posedge clock);
                end
                send_packet(PRIO_HIGH);
            end
        join
        wait_drained();
    endtask

    task automatic test_full_queue();
        test_name = "full_queue";
        @(posedge clock);
        out_ready <= 1'b0;
        build_packet(PRIO_LOW, FIFO_DEPTH);
        send_packet(PRIO_LOW);
        @(negedge clock);
        check_value("lp_ready", 0, lp_ready);
        check_value("hp_ready", 1, hp_ready);
        @(posedge clock);
        out_ready <= 1'b1;
        wait_drained();
    endtask

    always @(negedge clock) begin : monitor
        logic [DATA_WIDTH:0] expected;
        if (reset && out_valid) begin
            words_seen++;
            assert (expected_words.size() != 0) else begin
                $display("Output word %h in %s arrived while no word was expected",
                         {out_last, out_data}, test_name);
                stop_on_failure();
            end
            expected = expected_words.pop_front();
            check_value("output word", expected, {out_last, out_data});
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout in %s after %0d clock cycles", test_name, TIMEOUT_CYCLES);
            stop_on_failure();
        end
    end

    initial begin
        clock       = 1'b0;
        reset       = 1'b0;
        hp_data     = '0;
        hp_last     = 1'b0;
        hp_valid    = 1'b0;
        lp_data     = '0;
        lp_last     = 1'b0;
        lp_valid    = 1'b0;
        out_ready   = 1'b1;
        lfsr_state  = 32'd32;
        words_seen  = 0;
        cycle_count = 0;
        test_name   = "reset";
        repeat (16) @(posedge clock);
        reset <= 1'b1;
        test_low_packet();
        test_high_packet();
        test_priority();
        test_packet_locking();
        test_full_queue();
        if (expected_words.size() == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("The scoreboard still holds %0d words", expected_words.size());
            stop_on_failure();
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
stream_pkg.sv
framer_pkg.sv
dual_read_register_file.sv
prioritised_fifo.sv
packet_framer.sv
telemetry_mux.sv
telemetry_mux_assert.sv
tb_telemetry_mux.sv

// ==== run.sh ====
#!/bin/sh
# Builds the telemetry_mux testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_telemetry_mux -f tb.f -o tb_telemetry_mux > "$BUILD_LOG" 2>&1
build_status=$?
if [ "$build_status" -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_telemetry_mux > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "Regression failed" "$SIM_LOG"; then
    exit 1
fi
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation ended with status $sim_status"
    exit 1
fi
exit 0
